/* src.f */
hdl/tap_pkg.sv
hdl/host_pkg.sv
hdl/scan_req_if.sv
hdl/tck_divider.sv
hdl/scan_request.sv
hdl/tap_master.sv
hdl/tdo_capture.sv
hdl/jtag_host.sv
verification/tap_target_model.sv
verification/tb_jtag_host.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_jtag_host
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verification/tb_jtag_host.sv */
// JTAG host testbench
module tb_jtag_host;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	// tck periods per request, shift bits plus state walk
	localparam int SCAN_TCK = tap_pkg::IR_LENGTH + tap_pkg::DR_LENGTH + 12;
	localparam int MAX_SCANS = 60;
	// scan budget in ns, doubled
	localparam int WATCHDOG_NS = 2 * MAX_SCANS * SCAN_TCK * 2 * host_pkg::TCK_DIV * CLK_PERIOD;
	localparam int RANDOM_SCANS = 50;

	logic              clk;
	logic              rstn;
	logic              start;
	tap_pkg::ir_word_t ir;
	tap_pkg::dr_word_t dr;
	logic              tdo;
	logic              ready;
	logic              tck;
	logic              tms;
	logic              tdi;
	logic              trstn;
	tap_pkg::dr_word_t rdata;
	logic              rdata_valid;

	// target side
	tap_pkg::dr_word_t preload;
	tap_pkg::ir_word_t ir_rec;
	tap_pkg::dr_word_t dr_rec;
	logic [7:0]        ir_bits, dr_bits, ir_updates, dr_updates, illegal_count;
	logic              in_reset, in_idle;

	logic [31:0] rng_state;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	// readback monitor
	int valid_count = 0;
	int valid_while_ready = 0;
	tap_pkg::dr_word_t last_rdata;
	// tms-high run seen by the target in test-logic-reset
	int reset_tms_rises = 0;
	// expected values of the random run
	tap_pkg::ir_word_t exp_ir_q[$];
	tap_pkg::dr_word_t exp_dr_q[$];
	tap_pkg::dr_word_t exp_rd_q[$];

	jtag_host i_jtag_host (
		.clk         (clk),
		.rstn        (rstn),
		.start       (start),
		.ir          (ir),
		.dr          (dr),
		.tdo         (tdo),
		.ready       (ready),
		.tck         (tck),
		.tms         (tms),
		.tdi         (tdi),
		.trstn       (trstn),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

	tap_target_model i_tap_target_model (
		.tck           (tck),
		.tms           (tms),
		.tdi           (tdi),
		.trstn         (trstn),
		.preload       (preload),
		.tdo           (tdo),
		.ir_rec        (ir_rec),
		.dr_rec        (dr_rec),
		.ir_bits       (ir_bits),
		.dr_bits       (dr_bits),
		.ir_updates    (ir_updates),
		.dr_updates    (dr_updates),
		.illegal_count (illegal_count),
		.in_reset      (in_reset),
		.in_idle       (in_idle)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the scans did not complete", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

	// every rdata_valid pulse is counted, it must come before ready rises
	always @(posedge clk) begin
		if (rstn && rdata_valid) begin
			valid_count <= valid_count + 1;
			last_rdata  <= rdata;
			if (ready) begin
				valid_while_ready <= valid_while_ready + 1;
			end
		end
	end

	// rising tck with tms high while the target sits in test-logic-reset
	always @(posedge tck) begin
		if (trstn && in_reset && tms) begin
			reset_tms_rises <= reset_tms_rises + 1;
		end
	end

	// LCG, numerical recipes constants
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic draw_vectors(output tap_pkg::ir_word_t ir_v, output tap_pkg::dr_word_t dr_v,
			output tap_pkg::dr_word_t pre_v);
		logic [31:0] r;
		r = next_rand();
		ir_v = r[31:24];
		r = next_rand();
		dr_v = r[31:4];
		r = next_rand();
		pre_v = r[31:4];
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
			input logic [31:0] act);
		errors++;
		$display("FAILED at %0t ns: %s expected 0x%0h actual 0x%0h", $time, sig, exp, act);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		if (errors == errs_at_start) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail with %0d errors", name, errors - errs_at_start);
		end
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_ready();
		while (!ready) @(posedge clk);
	endtask

	// host side of the handshake, returns once the TAP has left idle
	task automatic launch_scan(input tap_pkg::ir_word_t ir_v, input tap_pkg::dr_word_t dr_v,
			input tap_pkg::dr_word_t pre_v);
		wait_ready();
		preload <= pre_v;
		ir      <= ir_v;
		dr      <= dr_v;
		start   <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (ready) @(posedge clk);
	endtask

	task automatic check_shifted(input tap_pkg::ir_word_t ir_v, input tap_pkg::dr_word_t dr_v,
			input logic [7:0] iu0, input logic [7:0] du0);
		if (ir_rec !== ir_v) report_mismatch("ir_rec", 32'(ir_v), 32'(ir_rec));
		if (dr_rec !== dr_v) report_mismatch("dr_rec", 32'(dr_v), 32'(dr_rec));
		if (ir_bits !== 8'(tap_pkg::IR_LENGTH)) begin
			report_mismatch("ir_bits", 32'(8), 32'(ir_bits));
		end
		if (dr_bits !== 8'(tap_pkg::DR_LENGTH)) begin
			report_mismatch("dr_bits", 32'(28), 32'(dr_bits));
		end
		if (ir_updates !== iu0 + 8'd1) report_problem("target did not see exactly one IR update");
		if (dr_updates !== du0 + 8'd1) report_problem("target did not see exactly one DR update");
		if (!in_idle) report_problem("target not in run-test-idle after the scan");
	endtask

	task automatic check_readback(input tap_pkg::dr_word_t pre_v, input int v0);
		if (valid_count != v0 + 1) begin
			report_mismatch("rdata_valid pulses", 32'(1), 32'(valid_count - v0));
		end
		if (last_rdata !== pre_v) report_mismatch("rdata", 32'(pre_v), 32'(last_rdata));
		if (valid_while_ready != 0) report_problem("rdata_valid pulsed while ready was high");
	endtask

	initial begin
		int errs0;
		int v0;
		int gap;
		logic [31:0] r;
		logic [7:0] iu0, du0;
		tap_pkg::ir_word_t ir_v, ir_alt;
		tap_pkg::dr_word_t dr_v, dr_alt, pre_v;

		rng_state = 32'h8b0c_b7b9;
		rstn    = 1'b0;
		start   = 1'b0;
		ir      = '0;
		dr      = '0;
		preload = '0;
		wait_clocks(10);

		// reset values, then the walk through test-logic-reset
		errs0 = errors;
		if (trstn !== 1'b0) report_mismatch("trstn", 32'(0), 32'(trstn));
		if (tck !== 1'b0) report_mismatch("tck", 32'(0), 32'(tck));
		if (tms !== 1'b0) report_mismatch("tms", 32'(0), 32'(tms));
		if (tdi !== 1'b0) report_mismatch("tdi", 32'(0), 32'(tdi));
		if (ready !== 1'b0) report_mismatch("ready", 32'(0), 32'(ready));
		if (rdata_valid !== 1'b0) report_mismatch("rdata_valid", 32'(0), 32'(rdata_valid));
		rstn <= 1'b1;
		while (trstn !== 1'b1) @(posedge clk);
		wait_ready();
		if (!in_idle) report_problem("target not in run-test-idle when ready rose");
		if (reset_tms_rises != tap_pkg::RESET_TMS_CYCLES) begin
			report_mismatch("reset_tms_rises", 32'(tap_pkg::RESET_TMS_CYCLES),
				32'(reset_tms_rises));
		end
		finish_test("1 reset", errs0);

		// one scan covers tests 2 and 3
		draw_vectors(ir_v, dr_v, pre_v);
		iu0 = ir_updates;
		du0 = dr_updates;
		v0  = valid_count;
		launch_scan(ir_v, dr_v, pre_v);
		wait_ready();
		errs0 = errors;
		check_shifted(ir_v, dr_v, iu0, du0);
		finish_test("2 single scan", errs0);
		errs0 = errors;
		check_readback(pre_v, v0);
		finish_test("3 readback", errs0);

		// second start during the scan, with vectors that surely differ
		errs0 = errors;
		draw_vectors(ir_v, dr_v, pre_v);
		r = next_rand();
		ir_alt = ir_v ^ (r[7:0] | 8'h01);
		dr_alt = dr_v ^ (r[31:4] | 28'h1);
		iu0 = ir_updates;
		du0 = dr_updates;
		v0  = valid_count;
		launch_scan(ir_v, dr_v, pre_v);
		wait_clocks(3);
		ir    <= ir_alt;
		dr    <= dr_alt;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		wait_ready();
		check_shifted(ir_v, dr_v, iu0, du0);
		check_readback(pre_v, v0);
		iu0 = ir_updates;
		// long enough for a whole stray scan to reach its IR update
		wait_clocks(SCAN_TCK * 2 * host_pkg::TCK_DIV);
		if (!ready) report_problem("a start issued while busy launched another scan");
		if (ir_updates !== iu0) report_problem("IR updated again after the ignored start");
		finish_test("4 start while busy", errs0);

		// back-to-back random scans with random idle gaps
		errs0 = errors;
		for (int n = 0; n < RANDOM_SCANS; n++) begin
			draw_vectors(ir_v, dr_v, pre_v);
			exp_ir_q.push_back(ir_v);
			exp_dr_q.push_back(dr_v);
			exp_rd_q.push_back(pre_v);
			r = next_rand();
			gap = int'(r[27:24]);
			wait_clocks(gap);
			iu0 = ir_updates;
			du0 = dr_updates;
			v0  = valid_count;
			launch_scan(ir_v, dr_v, pre_v);
			wait_ready();
			check_shifted(exp_ir_q.pop_front(), exp_dr_q.pop_front(), iu0, du0);
			check_readback(exp_rd_q.pop_front(), v0);
		end
		if (illegal_count !== 8'd0) report_mismatch("illegal_count", 32'(0), 32'(illegal_count));
		finish_test("5 random scans", errs0);

		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_passed + tests_failed, tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* verification/tap_target_model.sv */
// Single-device TAP model
module tap_target_model (
	input  logic              tck,
	input  logic              tms,
	input  logic              tdi,
	input  logic              trstn,
	input  tap_pkg::dr_word_t preload,
	output logic              tdo,
	output tap_pkg::ir_word_t ir_rec,
	output tap_pkg::dr_word_t dr_rec,
	output logic [7:0]        ir_bits,
	output logic [7:0]        dr_bits,
	output logic [7:0]        ir_updates,
	output logic [7:0]        dr_updates,
	output logic [7:0]        illegal_count,
	output logic              in_reset,
	output logic              in_idle
);
	timeunit 1ns;
	timeprecision 100ps;

	// full 16-state TAP of the standard
	typedef enum logic [3:0] {
		TLR, RTI, SEL_DR, CAP_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR,
		UPDATE_DR, SEL_IR, CAP_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
	} tap16_t;

	tap16_t state, next_state;
	// shift stages, dr stage also feeds tdo
	tap_pkg::ir_word_t ir_sh;
	tap_pkg::dr_word_t dr_sh;
	// next state is one the host must never reach
	logic bad;

	assign in_reset = (state == TLR);
	assign in_idle  = (state == RTI);

	always_comb begin
		bad = 1'b0;
		case (state)
			TLR:       next_state = tms ? TLR : RTI;
			RTI:       next_state = tms ? SEL_DR : RTI;
			SEL_DR:    next_state = tms ? SEL_IR : CAP_DR;
			CAP_DR:    next_state = tms ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR:  next_state = tms ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR:  next_state = tms ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR:  next_state = tms ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR:  next_state = tms ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR: next_state = tms ? SEL_DR : RTI;
			SEL_IR:    next_state = tms ? TLR : CAP_IR;
			CAP_IR:    next_state = tms ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR:  next_state = tms ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR:  next_state = tms ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR:  next_state = tms ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR:  next_state = tms ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR: next_state = tms ? SEL_DR : RTI;
			default: begin
				next_state = TLR;
				bad        = 1'b1;
			end
		endcase
		// host has no pause states
		if (next_state inside {PAUSE_DR, EXIT2_DR, PAUSE_IR, EXIT2_IR}) begin
			bad = 1'b1;
		end
		// test-logic-reset only once, right after trstn
		if (next_state == TLR && state != TLR) begin
			bad = 1'b1;
		end
	end

	// state moves and bits shift in on rising tck
	always @(posedge tck or negedge trstn) begin
		if (!trstn) begin
			state         <= TLR;
			ir_sh         <= '0;
			dr_sh         <= '0;
			ir_bits       <= '0;
			dr_bits       <= '0;
			illegal_count <= '0;
		end else begin
			if (bad || $isunknown(tms)) begin
				illegal_count <= illegal_count + 1'b1;
				$display("tap model: illegal state or unknown tms at %0t ns", $time);
			end
			state <= next_state;
			case (state)
				// capture pattern ends in 01 as the standard asks
				CAP_IR: begin
					ir_sh   <= tap_pkg::ir_word_t'(1);
					ir_bits <= '0;
				end
				SHIFT_IR: begin
					ir_sh   <= {tdi, ir_sh[tap_pkg::IR_LENGTH-1:1]};
					ir_bits <= ir_bits + 1'b1;
				end
				CAP_DR: begin
					dr_sh   <= preload;
					dr_bits <= '0;
				end
				SHIFT_DR: begin
					dr_sh   <= {tdi, dr_sh[tap_pkg::DR_LENGTH-1:1]};
					dr_bits <= dr_bits + 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	// tdo and the update registers change on falling tck
	always @(negedge tck or negedge trstn) begin
		if (!trstn) begin
			tdo        <= 1'b0;
			ir_rec     <= '0;
			dr_rec     <= '0;
			ir_updates <= '0;
			dr_updates <= '0;
		end else begin
			tdo <= (state == SHIFT_DR) ? dr_sh[0] : 1'b0;
			if (state == UPDATE_IR) begin
				ir_rec     <= ir_sh;
				ir_updates <= ir_updates + 1'b1;
			end
			if (state == UPDATE_DR) begin
				dr_rec     <= dr_sh;
				dr_updates <= dr_updates + 1'b1;
			end
		end
	end

endmodule

/* hdl/jtag_host.sv */
// JTAG host top level
module jtag_host (
	input  logic              clk,
	input  logic              rstn,
	input  logic              start,
	input  tap_pkg::ir_word_t ir,
	input  tap_pkg::dr_word_t dr,
	input  logic              tdo,
	output logic              ready,
	output logic              tck,
	output logic              tms,
	output logic              tdi,
	output logic              trstn,
	output tap_pkg::dr_word_t rdata,
	output logic              rdata_valid
);

	// request path between latch and sequencer
	scan_req_if req_bus ();

	logic tick;
	// readback strobes
	logic tdo_sample;
	logic scan_clear;
	logic scan_done;

	assign ready = req_bus.ready;

	tck_divider i_tck_divider (
		.clk  (clk),
		.rstn (rstn),
		.tick (tick)
	);

	scan_request i_scan_request (
		.clk   (clk),
		.rstn  (rstn),
		.start (start),
		.ir    (ir),
		.dr    (dr),
		.req   (req_bus.requester)
	);

	tap_master i_tap_master (
		.clk        (clk),
		.rstn       (rstn),
		.tick       (tick),
		.req        (req_bus.controller),
		.tck        (tck),
		.tms        (tms),
		.tdi        (tdi),
		.trstn      (trstn),
		.tdo_sample (tdo_sample),
		.scan_clear (scan_clear),
		.scan_done  (scan_done)
	);

	tdo_capture i_tdo_capture (
		.clk         (clk),
		.rstn        (rstn),
		.tdo         (tdo),
		.tdo_sample  (tdo_sample),
		.scan_clear  (scan_clear),
		.scan_done   (scan_done),
		.rdata       (rdata),
		.rdata_valid (rdata_valid)
	);

endmodule

/* hdl/tdo_capture.sv */
// TDO readback register
module tdo_capture (
	input  logic              clk,
	input  logic              rstn,
	input  logic              tdo,
	input  logic              tdo_sample,
	input  logic              scan_clear,
	input  logic              scan_done,
	output tap_pkg::dr_word_t rdata,
	output logic              rdata_valid
);

	// bits enter at the top and walk down to bit 0
	tap_pkg::dr_word_t shreg;

	always_ff @(posedge clk) begin
		if (scan_clear) begin
			shreg <= '0;
		end else if (tdo_sample) begin
			// first bit received ends up as the lsb
			shreg <= {tdo, shreg[tap_pkg::DR_LENGTH-1:1]};
		end
	end

	// result held until the next scan completes
	always_ff @(posedge clk) begin
		if (scan_done) begin
			rdata <= shreg;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rdata_valid <= 1'b0;
		end else begin
			// single clk pulse alongside the new rdata
			rdata_valid <= scan_done;
		end
	end

endmodule

/* hdl/tap_master.sv */
// TAP controller sequencer
module tap_master (
	input  logic           clk,
	input  logic           rstn,
	input  logic           tick,
	scan_req_if.controller req,
	output logic           tck,
	output logic           tms,
	output logic           tdi,
	output logic           trstn,
	output logic           tdo_sample,
	output logic           scan_clear,
	output logic           scan_done
);

	typedef logic [tap_pkg::SEL_WIDTH-1:0] sel_t;

	tap_pkg::tap_state_t cs, ns;
	// bit index into ir and dr, also counts the reset run
	sel_t sel;
	// start seen while idle, not yet acted on
	logic pending;
	logic tick_rise, tick_fall;
	tap_pkg::ir_word_t ir_shifted;
	tap_pkg::dr_word_t dr_shifted;

	// tck low now means this tick makes it rise
	assign tick_rise = tick && !tck;
	assign tick_fall = tick && tck;

	// current bit sits at position 0
	assign ir_shifted = req.ir >> sel;
	assign dr_shifted = req.dr >> sel;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			tck <= 1'b0;
		end else if (tick) begin
			tck <= ~tck;
		end
	end

	// state moves with rising tck, same edge the target uses
	always_ff @(posedge clk) begin
		if (!rstn) begin
			cs <= tap_pkg::POR;
		end else if (tick_rise) begin
			cs <= ns;
		end
	end

	always_comb begin
		ns = cs;
		case (cs)
			tap_pkg::POR:               ns = tap_pkg::TEST_LOGIC_RESET;
			// leave reset once the tms-high run is over
			tap_pkg::TEST_LOGIC_RESET:  if (!tms) ns = tap_pkg::RUN_TEST_IDLE;
			tap_pkg::RUN_TEST_IDLE:     if (tms) ns = tap_pkg::SELECT_DR_IR_SCAN;
			tap_pkg::SELECT_DR_IR_SCAN: ns = tap_pkg::SELECT_IR_SCAN;
			tap_pkg::SELECT_IR_SCAN:    ns = tap_pkg::CAPTURE_IR;
			tap_pkg::CAPTURE_IR:        ns = tap_pkg::SHIFT_IR;
			tap_pkg::SHIFT_IR: begin
				if (sel == sel_t'(tap_pkg::IR_LENGTH - 1)) ns = tap_pkg::EXIT1_IR;
			end
			tap_pkg::EXIT1_IR:          ns = tap_pkg::UPDATE_IR;
			tap_pkg::UPDATE_IR:         ns = tap_pkg::SELECT_DR_SCAN;
			tap_pkg::SELECT_DR_SCAN:    ns = tap_pkg::CAPTURE_DR;
			tap_pkg::CAPTURE_DR:        ns = tap_pkg::SHIFT_DR;
			tap_pkg::SHIFT_DR: begin
				if (sel == sel_t'(tap_pkg::DR_LENGTH - 1)) ns = tap_pkg::EXIT1_DR;
			end
			tap_pkg::EXIT1_DR:          ns = tap_pkg::UPDATE_DR;
			tap_pkg::UPDATE_DR:         ns = tap_pkg::RUN_TEST_IDLE;
			default:                    ns = tap_pkg::TEST_LOGIC_RESET;
		endcase
	end

	// start pulse may fall between ticks, keep it until tms picks it up
	always_ff @(posedge clk) begin
		if (!rstn) begin
			pending <= 1'b0;
		end else if (req.start) begin
			pending <= 1'b1;
		end else if (cs != tap_pkg::RUN_TEST_IDLE) begin
			pending <= 1'b0;
		end
	end

	// tms set on falling tck so it is stable at the next rising edge
	always_ff @(posedge clk) begin
		if (!rstn) begin
			tms <= 1'b0;
		end else if (tick_fall) begin
			tms <= 1'b0;
			case (cs)
				tap_pkg::TEST_LOGIC_RESET: begin
					tms <= (sel < sel_t'(tap_pkg::RESET_TMS_CYCLES));
				end
				tap_pkg::RUN_TEST_IDLE:     tms <= pending;
				// on to select-ir
				tap_pkg::SELECT_DR_IR_SCAN: tms <= 1'b1;
				tap_pkg::SHIFT_IR: begin
					tms <= (sel == sel_t'(tap_pkg::IR_LENGTH - 1));
				end
				tap_pkg::EXIT1_IR:          tms <= 1'b1;
				// straight into the dr scan
				tap_pkg::UPDATE_IR:         tms <= 1'b1;
				tap_pkg::SHIFT_DR: begin
					tms <= (sel == sel_t'(tap_pkg::DR_LENGTH - 1));
				end
				tap_pkg::EXIT1_DR:          tms <= 1'b1;
				default:                    tms <= 1'b0;
			endcase
		end
	end

	// index advances with each rising tck while shifting
	always_ff @(posedge clk) begin
		if (!rstn) begin
			sel <= '0;
		end else if (tick_rise) begin
			case (cs)
				tap_pkg::TEST_LOGIC_RESET: sel <= sel + 1'b1;
				tap_pkg::RUN_TEST_IDLE:    sel <= '0;
				tap_pkg::CAPTURE_IR:       sel <= '0;
				tap_pkg::CAPTURE_DR:       sel <= '0;
				tap_pkg::SHIFT_IR:         sel <= sel + 1'b1;
				tap_pkg::SHIFT_DR:         sel <= sel + 1'b1;
				default:                   sel <= sel;
			endcase
		end
	end

	// tdi presented on falling tck, lsb first
	always_ff @(posedge clk) begin
		if (!rstn) begin
			tdi <= 1'b0;
		end else if (tick_fall) begin
			case (cs)
				tap_pkg::SHIFT_IR: tdi <= ir_shifted[0];
				tap_pkg::SHIFT_DR: tdi <= dr_shifted[0];
				default:           tdi <= 1'b0;
			endcase
		end
	end

	// target reset released after the first tck period
	always_ff @(posedge clk) begin
		if (!rstn) begin
			trstn <= 1'b0;
		end else if (tick_fall) begin
			trstn <= (cs != tap_pkg::POR);
		end
	end

	assign req.ready = (cs == tap_pkg::RUN_TEST_IDLE);

	// capture strobes, all on rising tck ticks
	assign tdo_sample = tick_rise && (cs == tap_pkg::SHIFT_DR);
	assign scan_clear = tick_rise && (cs == tap_pkg::SELECT_DR_SCAN);
	assign scan_done  = tick_rise && (cs == tap_pkg::EXIT1_DR);

endmodule

/* hdl/scan_request.sv */
// Host request latch
module scan_request (
	input  logic              clk,
	input  logic              rstn,
	input  logic              start,
	input  tap_pkg::ir_word_t ir,
	input  tap_pkg::dr_word_t dr,
	scan_req_if.requester     req
);

	host_pkg::req_state_t state;
	// previous ready, for the rising edge at scan end
	logic ready_q;
	logic accept;

	// host start only counts while idle and the TAP is ready
	assign accept = start && req.ready && (state == host_pkg::IDLE);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state     <= host_pkg::IDLE;
			req.start <= 1'b0;
			ready_q   <= 1'b0;
		end else begin
			ready_q   <= req.ready;
			req.start <= 1'b0;
			case (state)
				host_pkg::IDLE: begin
					if (accept) begin
						state     <= host_pkg::BUSY;
						req.start <= 1'b1;
					end
				end
				host_pkg::BUSY: begin
					// ready drops when the TAP leaves idle, rises at scan end
					if (req.ready && !ready_q) begin
						state <= host_pkg::IDLE;
					end
				end
				default: state <= host_pkg::IDLE;
			endcase
		end
	end

	// vectors held for the whole scan
	always_ff @(posedge clk) begin
		if (accept) begin
			req.ir <= ir;
			req.dr <= dr;
		end
	end

endmodule

/* hdl/tck_divider.sv */
// TCK tick generator
module tck_divider (
	input  logic clk,
	input  logic rstn,
	output logic tick
);

	typedef logic [host_pkg::DIV_WIDTH-1:0] div_cnt_t;

	// down counter, reloads after reaching zero
	div_cnt_t cnt;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cnt  <= div_cnt_t'(host_pkg::TCK_DIV - 1);
			tick <= 1'b0;
		end else begin
			// one tick per TCK_DIV clks, no clock gating
			tick <= (cnt == '0);
			if (cnt == '0) begin
				cnt <= div_cnt_t'(host_pkg::TCK_DIV - 1);
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

/* hdl/scan_req_if.sv */
// Scan request bus
interface scan_req_if;

	// one clk pulse, only while ready is high
	logic start;
	// instruction, shifted lsb first
	tap_pkg::ir_word_t ir;
	// data word, shifted lsb first
	tap_pkg::dr_word_t dr;
	// high while the TAP sits in run-test-idle
	logic ready;

	// request latch side
	modport requester (
		output start,
		output ir,
		output dr,
		input  ready
	);

	// TAP sequencer side
	modport controller (
		input  start,
		input  ir,
		input  dr,
		output ready
	);

endinterface

/* hdl/host_pkg.sv */
// Host clocking and sequencing
package host_pkg;

	// clk cycles between two tck edges
	// one full tck period is twice this
	localparam int TCK_DIV = 4;

	// divider counter must hold TCK_DIV - 1
	localparam int DIV_WIDTH = 3;

	// request latch states
	// IDLE accepts a host start, BUSY waits for the scan to finish
	typedef enum logic {
		IDLE,
		BUSY
	} req_state_t;

endpackage

/* hdl/tap_pkg.sv */
// TAP protocol definitions
package tap_pkg;

	// instruction register length of the single target
	localparam int IR_LENGTH = 8;
	// data register length of the single target
	localparam int DR_LENGTH = 28;
	// bit index must reach DR_LENGTH
	localparam int SEL_WIDTH = 5;
	// tck periods with tms high to force test-logic-reset
	localparam int RESET_TMS_CYCLES = 5;

	typedef logic [IR_LENGTH-1:0] ir_word_t;
	typedef logic [DR_LENGTH-1:0] dr_word_t;

	// master view of the TAP, no pause states
	typedef enum logic [3:0] {
		POR,
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR_IR_SCAN,
		SELECT_IR_SCAN,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		UPDATE_IR,
		SELECT_DR_SCAN,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		UPDATE_DR
	} tap_state_t;

endpackage
